// File: hw/ahb_apb_pkg.sv
`default_nettype none

package ahb_apb_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int ADDR_W = 16;  // 64 KB APB address space
  localparam int DATA_W = 32;  // Single word data path

  // AHB HSIZE codes handled by the strobe decode
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;

  // --------------------
  // Bridge FSM encoding
  // --------------------
  typedef enum logic [2:0] {
    ST_IDLE      = 3'b000,  // No transfer, ready for a new one
    ST_APB_WAIT  = 3'b001,  // Accepted on AHB, pclken not seen yet
    ST_APB_TRNF  = 3'b010,  // APB setup phase
    ST_APB_TRNF2 = 3'b011,  // APB access phase, waits for pready
    ST_APB_ENDOK = 3'b100,  // OKAY end cycle, read data is valid
    ST_APB_ERR1  = 3'b101,  // First error cycle, hreadyout low
    ST_APB_ERR2  = 3'b110   // Second error cycle, hreadyout high
  } bridge_state_t;

  localparam logic [2:0] ST_CODE_ILLEGAL = 3'b111;  // Never reached

  // --------------------
  // Port groups
  // --------------------
  // Manager side inputs of the AHB-Lite subordinate port
  typedef struct packed {
    logic              hsel;
    logic [ADDR_W-1:0] haddr;
    logic [1:0]        htrans;  // Bit 1 marks NONSEQ or SEQ
    logic [2:0]        hsize;
    logic [3:0]        hprot;
    logic              hwrite;
    logic              hready;  // Previous data phase has ended
  } ahb_req_t;

  // Subordinate side outputs back to the manager
  typedef struct packed {
    logic              hreadyout;
    logic [DATA_W-1:0] hrdata;
    logic              hresp;   // 1 = ERROR
  } ahb_rsp_t;

  // Request as held for the APB completer
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;   // Low two bits always zero
    logic              pwrite;
    logic [3:0]        pstrb;   // Zero on reads
    logic [2:0]        pprot;
  } apb_req_t;

  // Completer response
  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: hw/ahb_request_capture.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_request_capture (
  input  wire                        HCLK,
  input  wire                        HRESETn,
  input  wire ahb_apb_pkg::ahb_req_t ahb_req,      // AHB address phase
  output ahb_apb_pkg::apb_req_t      apb_req,      // Held APB request
  output logic                       req_start,    // Transfer accepted this cycle
  output logic                       req_pending,  // Transfer seen, maybe not accepted
  output logic                       req_write     // Direction of the current phase
);

  import ahb_apb_pkg::*;

  logic [3:0] pstrb_nxt;  // Strobes for the address phase on the bus
  logic [2:0] pprot_nxt;  // APB protection from HPROT
  logic [1:0] lane;       // Byte lane within the word

  // --------------------
  // Select decode
  // --------------------
  assign req_pending = ahb_req.hsel & ahb_req.htrans[1];  // NONSEQ or SEQ
  assign req_start   = req_pending & ahb_req.hready;      // Accept needs hready
  assign req_write   = ahb_req.hwrite;

  assign lane = ahb_req.haddr[1:0];

  // --------------------
  // Byte strobes
  // --------------------
  // Only writes drive strobes, reads leave all lanes off
  always_comb
  begin
    pstrb_nxt = 4'b0000;
    if (ahb_req.hwrite)
    begin
      case (ahb_req.hsize)
        HSIZE_BYTE:
        begin
          pstrb_nxt[lane] = 1'b1;  // One lane from addr[1:0]
        end
        HSIZE_HALF:
        begin
          if (lane[1])
            pstrb_nxt = 4'b1100;   // Upper halfword
          else
            pstrb_nxt = 4'b0011;   // Lower halfword
        end
        default:
        begin
          pstrb_nxt = 4'b1111;     // Word, all lanes
        end
      endcase
    end
  end

  // Protection mapping
  // [0] privileged, [1] secure (always 0 here), [2] instruction
  assign pprot_nxt = {~ahb_req.hprot[0], 1'b0, ahb_req.hprot[1]};

  // --------------------
  // Request register
  // --------------------
  // Loaded at the accept edge, held for the whole APB transfer
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      apb_req <= '0;
    end
    else if (req_start)
    begin
      apb_req.paddr  <= {ahb_req.haddr[ADDR_W-1:2], 2'b00};  // Word aligned
      apb_req.pwrite <= ahb_req.hwrite;
      apb_req.pstrb  <= pstrb_nxt;
      apb_req.pprot  <= pprot_nxt;
    end
  end

  // Held read requests never carry strobes
  a_read_no_strobe : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !apb_req.pwrite |-> (apb_req.pstrb == 4'b0000));

endmodule

`default_nettype wire

// File: hw/apb_transfer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module apb_transfer_fsm (
  input  wire                        HCLK,
  input  wire                        HRESETn,
  input  wire                        req_start,    // AHB accept
  input  wire                        req_pending,  // Select seen, used for apbactive
  input  wire                        req_write,    // hwrite at accept
  input  wire                        pclken,       // APB clock enable
  input  wire ahb_apb_pkg::apb_rsp_t apb_rsp,      // From APB completer
  output ahb_apb_pkg::ahb_rsp_t      ahb_rsp,      // To AHB manager
  output logic                       psel,
  output logic                       penable,
  output logic                       apbactive     // Clock gating hint
);

  import ahb_apb_pkg::*;

  bridge_state_t     state_q;       // Current state
  bridge_state_t     state_d;       // Next state
  bridge_state_t     accept_state;  // Next state out of an accepting state
  logic              apb_done;      // Access phase completes this cycle
  logic              rdata_en;      // Load read data register
  logic              wr_q;          // Direction of the transfer in flight
  logic [DATA_W-1:0] rdata_q;       // Registered PRDATA

  // --------------------
  // Next state
  // --------------------
  // IDLE, ENDOK and ERR2 all take a new transfer the same way
  always_comb
  begin
    if (req_start && pclken)
      accept_state = ST_APB_TRNF;  // Setup phase next cycle
    else if (req_start)
      accept_state = ST_APB_WAIT;  // Hold until pclken
    else
      accept_state = ST_IDLE;
  end

  assign apb_done = (state_q == ST_APB_TRNF2) & pclken & apb_rsp.pready;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        state_d = accept_state;
      end
      ST_APB_WAIT:
      begin
        if (pclken)
          state_d = ST_APB_TRNF;
      end
      ST_APB_TRNF:
      begin
        if (pclken)
          state_d = ST_APB_TRNF2;  // Into access phase
      end
      ST_APB_TRNF2:
      begin
        if (apb_done && apb_rsp.pslverr)
          state_d = ST_APB_ERR1;   // Two cycle ERROR response
        else if (apb_done)
          state_d = ST_APB_ENDOK;
        // Otherwise completer is stalling, stay here
      end
      ST_APB_ENDOK:
      begin
        state_d = accept_state;    // Back to back allowed
      end
      ST_APB_ERR1:
      begin
        state_d = ST_APB_ERR2;
      end
      ST_APB_ERR2:
      begin
        state_d = accept_state;
      end
      default:
      begin
        state_d = ST_IDLE;         // Recover from the unused code
      end
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // --------------------
  // Direction and read data
  // --------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wr_q <= 1'b0;
    else if (req_start)
      wr_q <= req_write;
  end

  // Only an OKAY read loads the register, writes keep the old value
  assign rdata_en = apb_done & ~apb_rsp.pslverr & ~wr_q;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      rdata_q <= '0;
    else if (rdata_en)
      rdata_q <= apb_rsp.prdata;
  end

  // --------------------
  // Outputs
  // --------------------
  assign psel      = (state_q == ST_APB_TRNF) | (state_q == ST_APB_TRNF2);
  assign penable   = (state_q == ST_APB_TRNF2);
  assign apbactive = req_pending | (state_q != ST_IDLE);

  always_comb
  begin
    case (state_q)
      ST_IDLE:      ahb_rsp.hreadyout = 1'b1;  // Idle
      ST_APB_ENDOK: ahb_rsp.hreadyout = 1'b1;  // OKAY end, data phase done
      ST_APB_ERR2:  ahb_rsp.hreadyout = 1'b1;  // Last error cycle
      default:      ahb_rsp.hreadyout = 1'b0;  // Waiting, APB phases, ERR1
    endcase
    ahb_rsp.hresp  = (state_q == ST_APB_ERR1) | (state_q == ST_APB_ERR2);
    ahb_rsp.hrdata = rdata_q;
  end

  // --------------------
  // Assertions
  // --------------------
  a_state_legal : assert property (@(posedge HCLK) disable iff (!HRESETn)
    state_q != bridge_state_t'(ST_CODE_ILLEGAL));

  a_penable_psel : assert property (@(posedge HCLK) disable iff (!HRESETn)
    penable |-> psel);

  // ERROR is always the full two cycle sequence
  a_error_two_cycle : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (ahb_rsp.hresp && !ahb_rsp.hreadyout) |=> (ahb_rsp.hresp && ahb_rsp.hreadyout));

  // A completed write leaves hrdata untouched
  a_write_keeps_rdata : assert property (@(posedge HCLK) disable iff (!HRESETn)
    ((state_q == ST_APB_ENDOK) && wr_q) |-> $stable(ahb_rsp.hrdata));

endmodule

`default_nettype wire

// File: hw/ahb_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge (
  input  wire                               HCLK,
  input  wire                               HRESETn,
  input  wire                               pclken,     // APB rate enable
  input  wire ahb_apb_pkg::ahb_req_t        ahb_req,
  input  wire [ahb_apb_pkg::DATA_W-1:0]     hwdata,
  input  wire ahb_apb_pkg::apb_rsp_t        apb_rsp,
  output wire ahb_apb_pkg::ahb_rsp_t        ahb_rsp,
  output wire ahb_apb_pkg::apb_req_t        apb_req,
  output wire                               psel,
  output wire                               penable,
  output wire [ahb_apb_pkg::DATA_W-1:0]     pwdata,
  output wire                               apbactive
);

  wire req_start;    // Accept pulse from capture
  wire req_pending;  // Select seen on AHB
  wire req_write;    // Direction at accept

  // --------------------
  // Address phase capture
  // --------------------
  ahb_request_capture u_capture (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .ahb_req     (ahb_req),
    .apb_req     (apb_req),
    .req_start   (req_start),
    .req_pending (req_pending),
    .req_write   (req_write)
  );

  // --------------------
  // APB sequencing
  // --------------------
  apb_transfer_fsm u_fsm (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .req_start   (req_start),
    .req_pending (req_pending),
    .req_write   (req_write),
    .pclken      (pclken),
    .apb_rsp     (apb_rsp),
    .ahb_rsp     (ahb_rsp),
    .psel        (psel),
    .penable     (penable),
    .apbactive   (apbactive)
  );

  // HWDATA is valid for the whole APB transfer since hreadyout stays low
  assign pwdata = hwdata;

  // Request held steady once the completer sees psel
  a_req_stable : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (psel && $past(psel)) |-> $stable(apb_req));

  // An accepted transfer always stalls the next AHB cycle
  a_accept_stall : assert property (@(posedge HCLK) disable iff (!HRESETn)
    req_start |=> !ahb_rsp.hreadyout);

endmodule

`default_nettype wire

// File: tests/apb_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module apb_slave_model (
  input  wire                              HCLK,
  input  wire                              HRESETn,
  input  wire                              pclken,
  input  wire                              psel,
  input  wire                              penable,
  input  wire                              zero_wait,  // Force pready in the first access cycle
  input  wire ahb_apb_pkg::apb_req_t       apb_req,
  input  wire [ahb_apb_pkg::DATA_W-1:0]    pwdata,
  output ahb_apb_pkg::apb_rsp_t            apb_rsp,
  output ahb_apb_pkg::apb_req_t            rec_req,    // Request seen at the last completion
  output logic [ahb_apb_pkg::DATA_W-1:0]   rec_wdata,  // pwdata seen at the last completion
  output logic [31:0]                      rec_count   // Completed accesses
);

  import ahb_apb_pkg::*;

  integer            seed;
  logic [31:0]       rnd;
  logic [1:0]        wait_left = 2'd0;  // pclken cycles still to stall
  logic              armed     = 1'b0;  // Wait count chosen for this access
  logic              pready_r  = 1'b0;
  logic              pslverr_r = 1'b0;
  logic [DATA_W-1:0] prdata_r  = '0;
  logic              access_q;          // Access phase at the last rising edge
  logic              pclken_q;          // pclken at the last rising edge

  initial seed = 32'h73a7;

  assign apb_rsp.prdata  = prdata_r;
  assign apb_rsp.pready  = pready_r;
  assign apb_rsp.pslverr = pslverr_r;

  // --------------------
  // Completion record
  // --------------------
  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      access_q  <= 1'b0;
      pclken_q  <= 1'b0;
      rec_req   <= '0;
      rec_wdata <= '0;
      rec_count <= '0;
    end
    else
    begin
      access_q <= psel & penable;
      pclken_q <= pclken;
      if (psel && penable && pready_r && pclken)  // Access completes on this edge
      begin
        rec_req   <= apb_req;
        rec_wdata <= pwdata;
        rec_count <= rec_count + 32'd1;
      end
    end
  end

  // Response driven on the falling edge
  always @(negedge HCLK)
  begin
    if (!HRESETn)
    begin
      pready_r  = 1'b0;
      pslverr_r = 1'b0;
      prdata_r  = '0;
      armed     = 1'b0;
      wait_left = 2'd0;
    end
    else if (psel && !penable)
    begin
      if (!armed)  // Setup phase, pick 0 to 3 waits once
      begin
        rnd       = $random(seed);
        wait_left = zero_wait ? 2'd0 : rnd[1:0];
        armed     = 1'b1;
      end
      pready_r = 1'b0;
    end
    else if (psel && penable)
    begin
      // A stalled pclken edge in the access phase uses up one wait
      if (access_q && pclken_q && !pready_r && (wait_left != 2'd0))
        wait_left = wait_left - 2'd1;
      pready_r  = (wait_left == 2'd0);
      pslverr_r = (apb_req.paddr[ADDR_W-1 -: 4] == 4'hF);  // Error region
      prdata_r  = {{(DATA_W-ADDR_W){1'b0}}, apb_req.paddr} ^ 32'h5A5A0000;
    end
    else
    begin
      pready_r  = 1'b0;
      pslverr_r = 1'b0;
      prdata_r  = '0;
      armed     = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_ahb_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_apb_bridge;

  import ahb_apb_pkg::*;

  localparam int N_DIRECTED = 10;
  localparam int N_RANDOM   = 100;  // Per pclken mode
  localparam int N_EXPECTED = N_DIRECTED + 2 * N_RANDOM;
  // Reset plus 210 transfers at up to 24 cycles each at half rate with margin
  localparam int TIMEOUT_CYCLES = 6000;

  typedef struct packed {
    apb_req_t          req;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              resp;   // ERROR expected
  } xfer_exp_t;

  logic              HCLK   = 1'b0;
  logic              HRESETn;
  logic              pclken = 1'b1;
  ahb_req_t          ahb_req;
  logic [DATA_W-1:0] hwdata;
  apb_rsp_t          apb_rsp;
  ahb_rsp_t          ahb_rsp;
  apb_req_t          apb_req;
  logic              psel, penable, apbactive;
  logic [DATA_W-1:0] pwdata;
  apb_req_t          rec_req;
  logic [DATA_W-1:0] rec_wdata;
  logic [31:0]       rec_count;

  logic        div_mode, fixed_mode, zero_wait;  // Test phase controls
  integer      seed;
  int          cycles = 0;
  xfer_exp_t   exp_q[$];         // One entry per issued transfer
  xfer_exp_t   cur;              // Transfer in its data phase
  logic        busy = 1'b0;
  logic [31:0] lat;              // Cycles since the accept edge
  logic [31:0] n_done = '0;
  logic        acc_q, pclken_q;
  logic        psel_prev = 1'b0, penable_prev = 1'b0;
  logic        hresp_prev = 1'b0, ready_prev = 1'b1;

  ahb_apb_bridge UUT (
    .HCLK (HCLK), .HRESETn (HRESETn), .pclken (pclken), .ahb_req (ahb_req),
    .hwdata (hwdata), .apb_rsp (apb_rsp), .ahb_rsp (ahb_rsp), .apb_req (apb_req),
    .psel (psel), .penable (penable), .pwdata (pwdata), .apbactive (apbactive)
  );

  apb_slave_model u_completer (
    .HCLK (HCLK), .HRESETn (HRESETn), .pclken (pclken), .psel (psel),
    .penable (penable), .zero_wait (zero_wait), .apb_req (apb_req), .pwdata (pwdata),
    .apb_rsp (apb_rsp), .rec_req (rec_req), .rec_wdata (rec_wdata), .rec_count (rec_count)
  );

  always #10 HCLK = ~HCLK;

  always @(negedge HCLK)
  begin
    if (div_mode)
      pclken = ~pclken;  // Half rate APB
    else
      pclken = 1'b1;
  end

  // --------------------
  // Failure and checks
  // --------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_apb_req(input string name, input apb_req_t got, input apb_req_t want);
    if (got !== want)
      stop_run($sformatf("Error: %s expected %h got %h", name, want, got));
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] want);
    if (got !== want)
      stop_run($sformatf("Error: %s expected %h got %h", name, want, got));
  endtask

  task automatic check_resp(input string name, input logic got, input logic want);
    if (got !== want)
      stop_run($sformatf("Error: %s expected %h got %h", name, want, got));
  endtask

  always @(posedge HCLK)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      stop_run("Timeout: the transfers did not all finish in the cycle limit");
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic apb_req_t exp_apb_req(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                                           input logic write, input logic [3:0] prot);
    apb_req_t r;
    r.paddr      = addr;
    r.paddr[1:0] = 2'b00;     // Word address on APB
    r.pwrite     = write;
    r.pprot[0]   = prot[1];   // Privileged
    r.pprot[1]   = 1'b0;      // Secure
    r.pprot[2]   = !prot[0];  // Instruction unless a data access
    if (!write)
      r.pstrb = 4'b0000;
    else if (size == 3'd0)
      r.pstrb = 4'b0001 << addr[1:0];
    else if (size == 3'd1)
      r.pstrb = addr[1] ? 4'b1100 : 4'b0011;
    else
      r.pstrb = 4'b1111;
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] exp_rdata(input logic [ADDR_W-1:0] addr);
    return {{(DATA_W-ADDR_W){1'b0}}, addr[ADDR_W-1:2], 2'b00} ^ 32'h5A5A0000;
  endfunction

  // --------------------
  // AHB manager
  // --------------------
  // Address phase then data phase until hreadyout
  // hready follows hreadyout as on a single subordinate bus
  task automatic ahb_transfer(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                              input logic write, input logic [3:0] prot,
                              input logic [DATA_W-1:0] wdata);
    xfer_exp_t e;
    while (!ahb_rsp.hreadyout)
    begin
      @(negedge HCLK);
      ahb_req.hready = ahb_rsp.hreadyout;
    end
    e.req   = exp_apb_req(addr, size, write, prot);
    e.wdata = wdata;
    e.rdata = exp_rdata(addr);
    e.resp  = (addr[ADDR_W-1 -: 4] == 4'hF);
    exp_q.push_back(e);
    ahb_req = '{hsel: 1'b1, haddr: addr, htrans: 2'b10, hsize: size, hprot: prot,
                hwrite: write, hready: 1'b1};  // NONSEQ
    @(negedge HCLK);
    ahb_req.hsel   = 1'b0;
    ahb_req.htrans = 2'b00;
    ahb_req.hready = ahb_rsp.hreadyout;
    hwdata         = wdata;               // Data phase
    while (!ahb_rsp.hreadyout)
    begin
      @(negedge HCLK);
      ahb_req.hready = ahb_rsp.hreadyout;
    end
  endtask

  task automatic random_transfer;
    logic [31:0]       r_addr, r_ctl, r_data;
    logic [2:0]        size;
    logic [ADDR_W-1:0] addr;
    r_addr = $random(seed);
    r_ctl  = $random(seed);
    r_data = $random(seed);
    size   = (r_ctl[1:0] == 2'b11) ? 3'd2 : {1'b0, r_ctl[1:0]};
    addr   = r_addr[ADDR_W-1:0];
    if (size == 3'd1)
      addr[0] = 1'b0;        // Aligned halfword
    else if (size == 3'd2)
      addr[1:0] = 2'b00;     // Aligned word
    ahb_transfer(addr, size, r_ctl[2], r_ctl[6:3], r_data);
  endtask

  // --------------------
  // Compare process
  // --------------------
  always @(posedge HCLK)
  begin
    acc_q    <= HRESETn & ahb_req.hsel & ahb_req.htrans[1] & ahb_req.hready;
    pclken_q <= pclken;
  end

  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      if ((psel || !ahb_rsp.hreadyout) && !apbactive)
        stop_run("apbactive was low while a transfer was in progress");
      if (((psel != psel_prev) || (penable != penable_prev)) && !pclken_q)
        stop_run("psel or penable changed after a cycle without pclken");
      if (acc_q)
      begin
        cur  = exp_q.pop_front();
        busy = 1'b1;
        lat  = '0;
      end
      if (busy)
      begin
        lat = lat + 32'd1;
        if (fixed_mode && (lat == 32'd1))
        begin
          check_resp("psel", psel, 1'b1);
          check_resp("penable", penable, 1'b0);
        end
        if (fixed_mode && (lat == 32'd2))
          check_resp("penable", penable, 1'b1);
        if (ahb_rsp.hreadyout)   // Data phase ends
        begin
          if (fixed_mode)
            check_data("latency", lat, cur.resp ? 32'd4 : 32'd3);
          if (rec_count != n_done + 32'd1)
            stop_run("The APB completer did not see exactly one access for the transfer");
          check_apb_req("apb_req", rec_req, cur.req);
          check_resp("hresp", ahb_rsp.hresp, cur.resp);
          if (cur.resp)
          begin
            check_resp("hresp in first error cycle", hresp_prev, 1'b1);
            check_resp("hreadyout in first error cycle", ready_prev, 1'b0);
          end
          if (cur.req.pwrite)
            check_data("pwdata", rec_wdata, cur.wdata);
          else if (!cur.resp)
            check_data("hrdata", ahb_rsp.hrdata, cur.rdata);
          n_done = n_done + 32'd1;
          busy   = 1'b0;
        end
      end
      psel_prev    = psel;
      penable_prev = penable;
      hresp_prev   = ahb_rsp.hresp;
      ready_prev   = ahb_rsp.hreadyout;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial
  begin
    seed       = 32'h73a7;
    HRESETn    = 1'b0;
    ahb_req    = '0;
    hwdata     = '0;
    div_mode   = 1'b0;
    fixed_mode = 1'b1;
    zero_wait  = 1'b1;
    repeat (10) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    check_resp("hreadyout", ahb_rsp.hreadyout, 1'b1);
    check_resp("psel", psel, 1'b0);
    check_resp("penable", penable, 1'b0);
    check_resp("hresp", ahb_rsp.hresp, 1'b0);
    check_resp("apbactive", apbactive, 1'b0);
    check_apb_req("apb_req", apb_req, '0);

    // Every byte lane, both halfwords, a word, a read and two error accesses
    for (int i = 0; i < 4; i++)
      ahb_transfer(16'h1200 + 16'(i), 3'd0, 1'b1, 4'b0011, 32'hA0B0C0D0 ^ 32'(i));
    ahb_transfer(16'h2340, 3'd1, 1'b1, 4'b0010, 32'h11223344);
    ahb_transfer(16'h2342, 3'd1, 1'b1, 4'b0001, 32'h55667788);
    ahb_transfer(16'h3454, 3'd2, 1'b1, 4'b0000, 32'h99AABBCC);
    ahb_transfer(16'h4564, 3'd2, 1'b0, 4'b0011, 32'h0);
    ahb_transfer(16'hF010, 3'd2, 1'b0, 4'b0001, 32'h0);
    ahb_transfer(16'hF026, 3'd1, 1'b1, 4'b0010, 32'h13572468);

    @(negedge HCLK);
    fixed_mode = 1'b0;    // Random waits from here on
    zero_wait  = 1'b0;
    repeat (N_RANDOM) random_transfer();
    @(negedge HCLK);
    div_mode = 1'b1;
    repeat (N_RANDOM) random_transfer();
    repeat (4) @(negedge HCLK);
    if (busy || (exp_q.size() != 0) || (n_done != N_EXPECTED))
      stop_run("Not every issued transfer finished on the AHB side");
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/ahb_apb_pkg.sv
hw/ahb_request_capture.sv
hw/apb_transfer_fsm.sv
hw/ahb_apb_bridge.sv
tests/apb_slave_model.sv
tests/tb_ahb_apb_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ahb_apb_bridge \
  -Mdir obj_dir \
  -f vlog.f

./obj_dir/Vtb_ahb_apb_bridge
